//--- hw/spw_tx_cfg.svh
// Limits and character lengths for the SpaceWire transmitter.
// Include in any file that sizes counters or loads characters.

`ifndef SPW_TX_CFG_SVH
`define SPW_TX_CFG_SVH

// Flow control limits
`define SPW_CREDIT_MAX 56
`define SPW_CREDIT_STEP 8
`define SPW_FCT_MAX 7

// Character lengths in bits, parity included
`define SPW_LEN_NULL 8
`define SPW_LEN_CTRL 4
`define SPW_LEN_DATA 10
`define SPW_LEN_TIME 14

`endif

//--- hw/spw_char_pkg.sv
// Link character definitions shared by the sequencer and serializer.
// Bit patterns are stored first bit first, so bit 0 leaves the line first.

package spw_char_pkg;

	// --------------------
	// Character kinds
	// --------------------
	typedef enum logic [2:0] {
		CHAR_NULL = 3'd0,
		CHAR_FCT  = 3'd1,
		CHAR_EOP  = 3'd2,
		CHAR_EEP  = 3'd3,
		CHAR_DATA = 3'd4,
		CHAR_TIME = 3'd5
	} spw_char_kind_t;

	// Host data word; flag marks a packet end, data[0] then picks EOP or EEP
	typedef struct packed {
		logic       flag;
		logic [7:0] data;
	} spw_nchar_t;

	// One character request towards the serializer
	typedef struct packed {
		spw_char_kind_t kind;
		logic [7:0]     payload;
	} spw_char_req_t;

	// --------------------
	// Control codes
	// --------------------
	// Two payload bits after the control flag
	localparam logic [1:0] CODE_FCT = 2'b00;
	localparam logic [1:0] CODE_EOP = 2'b10;
	localparam logic [1:0] CODE_EEP = 2'b01;
	localparam logic [1:0] CODE_ESC = 2'b11;

	// ESC then FCT, both parity positions left at zero
	localparam logic [7:0] NULL_BITS = 8'b0010_1110;

endpackage

//--- hw/spw_tx_pkg.sv
// Transmitter-side types: sequencer state and flow control counters.
// Counter widths follow the limits in the config header.

`include "spw_tx_cfg.svh"

package spw_tx_pkg;

	// --------------------
	// Sequencer state
	// --------------------
	// Startup sends only NULL and FCT until the first FCT goes out
	typedef enum logic {
		TX_STARTUP = 1'b0,
		TX_RUN     = 1'b1
	} spw_tx_state_t;

	// --------------------
	// Counters
	// --------------------
	// Credit in data characters the far end can accept
	typedef logic [$clog2(`SPW_CREDIT_MAX + 1) - 1:0] spw_credit_t;

	// Outstanding FCTs requested by the receiver
	typedef logic [$clog2(`SPW_FCT_MAX + 1) - 1:0] spw_fct_cnt_t;

endpackage

//--- hw/spw_tx_flow_ctl.sv
// Transmit flow control: credit from received FCTs and the count of
// FCTs still owed to the far end. Both update one clock after a pulse.

`timescale 1ns/1ns
`include "spw_tx_cfg.svh"

module spw_tx_flow_ctl (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic gotfct_tx,
	input  logic send_fct_now,
	input  logic data_sent,
	input  logic fct_sent,
	output logic credit_avail,
	output logic fct_pending
);

	import spw_tx_pkg::*;

	spw_credit_t                    credit;
	spw_fct_cnt_t                   fct_cnt;
	logic [$bits(spw_credit_t):0]   credit_next;

	// One spare bit so the add can pass the ceiling before clipping
	always_comb
	begin
		credit_next = {1'b0, credit};
		if (gotfct_tx)
			credit_next = credit_next + ($bits(credit_next))'(`SPW_CREDIT_STEP);
		if (credit_next > ($bits(credit_next))'(`SPW_CREDIT_MAX))
			credit_next = ($bits(credit_next))'(`SPW_CREDIT_MAX);
		if (data_sent && credit_next != '0)
			credit_next = credit_next - 1'b1;
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			credit  <= '0;
			fct_cnt <= '0;
		end
		else
		begin
			credit <= credit_next[$bits(spw_credit_t) - 1:0];

			// Request and completion together leave the count as it is
			if (send_fct_now && !fct_sent && fct_cnt != ($bits(fct_cnt))'(`SPW_FCT_MAX))
				fct_cnt <= fct_cnt + 1'b1;
			else if (fct_sent && !send_fct_now && fct_cnt != '0)
				fct_cnt <= fct_cnt - 1'b1;
		end
	end

	assign credit_avail = (credit != '0);
	assign fct_pending  = (fct_cnt != '0);

endmodule

//--- hw/spw_tx_seq.sv
// Character sequencer. At every character boundary it picks the next
// character by priority and holds it for the serializer, one character
// ahead of the line. Also raises the consumption and completion pulses.

`timescale 1ns/1ns

module spw_tx_seq (
	input  logic                       pclk_tx,
	input  logic                       enable_tx,
	input  logic                       send_null_tx,
	input  logic                       send_fct_tx,
	input  spw_char_pkg::spw_nchar_t   tx_data_in,
	input  logic                       process_data,
	input  logic [7:0]                 tx_tcode_in,
	input  logic                       tcode_rdy_trnsp,
	input  logic                       char_last,
	input  logic                       credit_avail,
	input  logic                       fct_pending,
	output spw_char_pkg::spw_char_req_t next_char,
	output logic                       data_sent,
	output logic                       fct_sent,
	output logic                       ready_tx_data,
	output logic                       ready_tx_timecode
);

	import spw_char_pkg::*;
	import spw_tx_pkg::*;

	spw_tx_state_t state;
	spw_char_req_t choice;
	logic          fct_ok;
	logic          data_ok;
	logic          time_ok;
	logic          cur_time;
	logic          tcode_busy;
	logic          advance;

	// Boundaries only come while the line advances
	assign advance = char_last && send_null_tx;

	// --------------------
	// Priority pick
	// --------------------
	always_comb
	begin
		fct_ok  = send_fct_tx && fct_pending;
		data_ok = process_data && credit_avail;
		// Time code already queued or on the line is not picked twice
		time_ok = tcode_rdy_trnsp && !tcode_busy;

		choice.kind    = CHAR_NULL;
		choice.payload = '0;

		if (state == TX_STARTUP)
		begin
			if (fct_ok)
				choice.kind = CHAR_FCT;
		end
		else if (time_ok)
		begin
			choice.kind    = CHAR_TIME;
			choice.payload = tx_tcode_in;
		end
		else if (fct_ok)
		begin
			choice.kind = CHAR_FCT;
		end
		else if (data_ok)
		begin
			if (!tx_data_in.flag)
			begin
				choice.kind    = CHAR_DATA;
				choice.payload = tx_data_in.data;
			end
			else if (tx_data_in.data[0])
				choice.kind = CHAR_EEP;
			else
				choice.kind = CHAR_EOP;
		end
	end

	// --------------------
	// Request register and pulses
	// --------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state             <= TX_STARTUP;
			next_char         <= '{kind: CHAR_NULL, payload: '0};
			cur_time          <= 1'b0;
			tcode_busy        <= 1'b0;
			data_sent         <= 1'b0;
			fct_sent          <= 1'b0;
			ready_tx_timecode <= 1'b0;
		end
		else
		begin
			data_sent         <= 1'b0;
			fct_sent          <= 1'b0;
			// Last bit of a time code leaves on this edge
			ready_tx_timecode <= advance && cur_time;

			if (advance && cur_time)
				tcode_busy <= 1'b0;

			if (advance)
			begin
				next_char <= choice;
				// Serializer takes the held request on this same edge
				cur_time  <= (next_char.kind == CHAR_TIME);

				case (choice.kind)
				CHAR_FCT:
				begin
					fct_sent <= 1'b1;
					state    <= TX_RUN;
				end
				CHAR_DATA, CHAR_EOP, CHAR_EEP:
				begin
					data_sent <= 1'b1;
				end
				CHAR_TIME:
				begin
					tcode_busy <= 1'b1;
				end
				default:
				begin
				end
				endcase
			end
		end
	end

	// Host word is consumed when it becomes a request
	assign ready_tx_data = data_sent;

endmodule

//--- hw/spw_tx_char_enc.sv
// Character serializer. Loads a request with its parity bits filled in,
// shifts it out one bit per advancing clock and drives data/strobe so
// that exactly one of the two changes per bit.

`timescale 1ns/1ns
`include "spw_tx_cfg.svh"

module spw_tx_char_enc (
	input  logic                        pclk_tx,
	input  logic                        enable_tx,
	input  logic                        send_null_tx,
	input  spw_char_pkg::spw_char_req_t next_char,
	output logic                        char_last,
	output logic                        tx_dout_e,
	output logic                        tx_sout_e
);

	import spw_char_pkg::*;

	logic [13:0] shift_q;
	logic [3:0]  bits_left;
	logic        prev_par;
	logic [13:0] load_bits;
	logic [3:0]  load_len;
	logic        load_par;
	logic        line_bit;

	// --------------------
	// Character build
	// --------------------
	// Odd parity over parity, own flag and the previous payload:
	// a control flag gives prev_par, a data flag gives its inverse
	always_comb
	begin
		load_bits = '0;
		load_len  = 4'(`SPW_LEN_NULL);
		load_par  = 1'b0;

		case (next_char.kind)
		CHAR_FCT:
		begin
			load_bits = {10'd0, CODE_FCT, 1'b1, prev_par};
			load_len  = 4'(`SPW_LEN_CTRL);
		end
		CHAR_EOP:
		begin
			load_bits = {10'd0, CODE_EOP, 1'b1, prev_par};
			load_len  = 4'(`SPW_LEN_CTRL);
			load_par  = 1'b1;
		end
		CHAR_EEP:
		begin
			load_bits = {10'd0, CODE_EEP, 1'b1, prev_par};
			load_len  = 4'(`SPW_LEN_CTRL);
			load_par  = 1'b1;
		end
		CHAR_DATA:
		begin
			load_bits = {4'd0, next_char.payload, 1'b0, ~prev_par};
			load_len  = 4'(`SPW_LEN_DATA);
			load_par  = ^next_char.payload;
		end
		CHAR_TIME:
		begin
			// ESC payload is even, so the inner parity bit is always 1
			load_bits = {next_char.payload, 1'b0, 1'b1, CODE_ESC, 1'b1, prev_par};
			load_len  = 4'(`SPW_LEN_TIME);
			load_par  = ^next_char.payload;
		end
		default:
		begin
			// NULL; the second parity bit stays 0 behind ESC
			load_bits = {6'd0, NULL_BITS[7:1], prev_par};
		end
		endcase
	end

	// Empty only right after reset, then load without sending a bit
	assign char_last = (bits_left <= 4'd1);
	assign line_bit  = shift_q[0];

	always_ff @(posedge pclk_tx)
	begin
		if (send_null_tx)
		begin
			if (char_last)
				shift_q <= load_bits;
			else
				shift_q <= shift_q >> 1;
		end
	end

	// --------------------
	// Bit count and line
	// --------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			bits_left <= 4'd0;
			prev_par  <= 1'b0;
			tx_dout_e <= 1'b0;
			tx_sout_e <= 1'b0;
		end
		else if (send_null_tx)
		begin
			if (bits_left != 4'd0)
			begin
				tx_dout_e <= line_bit;
				// Strobe carries the edge when data repeats
				if (line_bit == tx_dout_e)
					tx_sout_e <= ~tx_sout_e;
			end

			if (char_last)
			begin
				bits_left <= load_len;
				prev_par  <= load_par;
			end
			else
				bits_left <= bits_left - 4'd1;
		end
	end

endmodule

//--- hw/spw_tx_top.sv
// SpaceWire transmitter top level. Connects flow control, sequencer
// and serializer; send_null_tx advances the whole path by one bit.

`timescale 1ns/1ns

module spw_tx_top (
	input  logic                     pclk_tx,
	input  logic                     enable_tx,
	input  logic                     send_null_tx,
	input  logic                     send_fct_tx,
	input  spw_char_pkg::spw_nchar_t tx_data_in,
	input  logic                     process_data,
	input  logic                     gotfct_tx,
	input  logic                     send_fct_now,
	input  logic [7:0]               tx_tcode_in,
	input  logic                     tcode_rdy_trnsp,
	output logic                     tx_dout_e,
	output logic                     tx_sout_e,
	output logic                     ready_tx_data,
	output logic                     ready_tx_timecode,
	output logic                     fct_great_than_zero
);

	import spw_char_pkg::*;

	spw_char_req_t next_char;
	logic          char_last;
	logic          data_sent;
	logic          fct_sent;
	logic          credit_avail;
	logic          fct_pending;

	spw_tx_flow_ctl flow_ctl_i (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.gotfct_tx    (gotfct_tx),
		.send_fct_now (send_fct_now),
		.data_sent    (data_sent),
		.fct_sent     (fct_sent),
		.credit_avail (credit_avail),
		.fct_pending  (fct_pending)
	);

	spw_tx_seq seq_i (
		.pclk_tx           (pclk_tx),
		.enable_tx         (enable_tx),
		.send_null_tx      (send_null_tx),
		.send_fct_tx       (send_fct_tx),
		.tx_data_in        (tx_data_in),
		.process_data      (process_data),
		.tx_tcode_in       (tx_tcode_in),
		.tcode_rdy_trnsp   (tcode_rdy_trnsp),
		.char_last         (char_last),
		.credit_avail      (credit_avail),
		.fct_pending       (fct_pending),
		.next_char         (next_char),
		.data_sent         (data_sent),
		.fct_sent          (fct_sent),
		.ready_tx_data     (ready_tx_data),
		.ready_tx_timecode (ready_tx_timecode)
	);

	spw_tx_char_enc char_enc_i (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.send_null_tx (send_null_tx),
		.next_char    (next_char),
		.char_last    (char_last),
		.tx_dout_e    (tx_dout_e),
		.tx_sout_e    (tx_sout_e)
	);

	assign fct_great_than_zero = credit_avail;

endmodule

//--- verif/spw_tx_clkgen.sv
// Clock and reset source for the transmitter testbench.
// Reset is held low for a fixed number of cycles, then released.

`timescale 1ns/1ns

module spw_tx_clkgen #(
	parameter int PERIOD     = 10,
	parameter int RST_CYCLES = 8
) (
	output logic pclk_tx,
	output logic enable_tx
);

	initial
	begin
		pclk_tx = 1'b0;
		forever
			#(PERIOD / 2) pclk_tx = ~pclk_tx;
	end

	initial
	begin
		enable_tx = 1'b0;
		repeat (RST_CYCLES) @(posedge pclk_tx);
		#1 enable_tx = 1'b1;
	end

endmodule

//--- verif/spw_tx_assert.sv
// Line protocol checks for the transmitter, bound to the top level.
// Covers data/strobe encoding, freeze on back-pressure and pulse widths.

`timescale 1ns/1ns

module spw_tx_assert (
	input logic pclk_tx,
	input logic enable_tx,
	input logic send_null_tx,
	input logic tx_dout_e,
	input logic tx_sout_e,
	input logic ready_tx_data,
	input logic ready_tx_timecode
);

	// Number of failed checks so far
	int fail_count = 0;

	// Never both line outputs in one clock
	one_change: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!($changed(tx_dout_e) && $changed(tx_sout_e)))
		else
		begin
			fail_count++;
			$error("data and strobe changed together");
		end

	// Held line while the link does not advance
	line_frozen: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!send_null_tx |=> ($stable(tx_dout_e) && $stable(tx_sout_e)))
		else
		begin
			fail_count++;
			$error("line moved while send_null_tx was low");
		end

	data_pulse: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_tx_data |=> !ready_tx_data)
		else
		begin
			fail_count++;
			$error("ready_tx_data longer than one cycle");
		end

	tcode_pulse: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_tx_timecode |=> !ready_tx_timecode)
		else
		begin
			fail_count++;
			$error("ready_tx_timecode longer than one cycle");
		end

endmodule

bind spw_tx_top spw_tx_assert assert_i (.*);

//--- verif/spw_tx_tb.sv
// Directed testbench for the SpaceWire transmitter. A line decoder turns
// data/strobe changes back into characters; each test checks that stream.

`timescale 1ns/1ns

module spw_tx_tb;

	import spw_char_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RST_CYCLES = 8;
	// Rough cycle budget per test, summed for the watchdog
	localparam int BUDGET = 400 + 900 + 900 + 700 + 500 + 600;

	logic          pclk_tx;
	logic          enable_tx;
	logic          send_null_tx;
	logic          send_fct_tx;
	spw_nchar_t    tx_data_in;
	logic          process_data;
	logic          gotfct_tx;
	logic          send_fct_now;
	logic [7:0]    tx_tcode_in;
	logic          tcode_rdy_trnsp;
	logic          tx_dout_e;
	logic          tx_sout_e;
	logic          ready_tx_data;
	logic          ready_tx_timecode;
	logic          fct_great_than_zero;

	spw_char_req_t dec_q[$];
	int            data_pulses;
	int            tcode_pulses;
	int            error_count;
	int            seed;

	spw_tx_clkgen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) clkgen_i (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx)
	);

	spw_tx_top dut_i (
		.pclk_tx             (pclk_tx),
		.enable_tx           (enable_tx),
		.send_null_tx        (send_null_tx),
		.send_fct_tx         (send_fct_tx),
		.tx_data_in          (tx_data_in),
		.process_data        (process_data),
		.gotfct_tx           (gotfct_tx),
		.send_fct_now        (send_fct_now),
		.tx_tcode_in         (tx_tcode_in),
		.tcode_rdy_trnsp     (tcode_rdy_trnsp),
		.tx_dout_e           (tx_dout_e),
		.tx_sout_e           (tx_sout_e),
		.ready_tx_data       (ready_tx_data),
		.ready_tx_timecode   (ready_tx_timecode),
		.fct_great_than_zero (fct_great_than_zero)
	);

	// --------------------
	// Reporting
	// --------------------
	task automatic report_mismatch(input string name, input int exp, input int act);
		error_count++;
		$display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR at %0t: %s", $time, msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	// Bound line protocol checks
	always @(dut_i.assert_i.fail_count)
	begin
		if (dut_i.assert_i.fail_count != 0)
			report_error("line protocol assertion failed");
	end

	// --------------------
	// Line decoder
	// --------------------
	logic last_d;
	logic last_s;

	task automatic read_bit(output logic b);
		do
			@(negedge pclk_tx);
		while (tx_dout_e == last_d && tx_sout_e == last_s);
		assert (!(tx_dout_e != last_d && tx_sout_e != last_s))
			else report_error("data and strobe changed in the same bit");
		b = tx_dout_e;
		last_d = tx_dout_e;
		last_s = tx_sout_e;
	endtask

	task automatic read_byte(output logic [7:0] v);
		logic b;
		for (int i = 0; i < 8; i++)
		begin
			read_bit(b);
			v[i] = b;
		end
	endtask

	initial
	begin : decoder
		logic          p;
		logic          f;
		logic          c0;
		logic          c1;
		logic          prev;
		logic [7:0]    v;
		spw_char_req_t c;
		last_d = 1'b0;
		last_s = 1'b0;
		prev   = 1'b0;
		@(posedge enable_tx);
		forever
		begin
			read_bit(p);
			read_bit(f);
			assert (p ^ f ^ prev)
				else report_error("parity error on decoded character");
			c.payload = '0;
			if (!f)
			begin
				read_byte(v);
				prev      = ^v;
				c.kind    = CHAR_DATA;
				c.payload = v;
			end
			else
			begin
				read_bit(c0);
				read_bit(c1);
				prev = c0 ^ c1;
				if ({c1, c0} == CODE_FCT)
					c.kind = CHAR_FCT;
				else if ({c1, c0} == CODE_EOP)
					c.kind = CHAR_EOP;
				else if ({c1, c0} == CODE_EEP)
					c.kind = CHAR_EEP;
				else
				begin
					// Escape, so NULL or time code follows
					read_bit(p);
					read_bit(f);
					assert (p ^ f ^ prev)
						else report_error("parity error after escape");
					if (f)
					begin
						read_bit(c0);
						read_bit(c1);
						assert ({c1, c0} == CODE_FCT)
							else report_error("escape followed by a control other than FCT");
						prev   = 1'b0;
						c.kind = CHAR_NULL;
					end
					else
					begin
						read_byte(v);
						prev      = ^v;
						c.kind    = CHAR_TIME;
						c.payload = v;
					end
				end
			end
			dec_q.push_back(c);
		end
	end

	always @(negedge pclk_tx)
	begin
		if (enable_tx && ready_tx_data)
			data_pulses++;
		if (enable_tx && ready_tx_timecode)
			tcode_pulses++;
	end

	// --------------------
	// Helpers
	// --------------------
	task automatic tick();
		@(posedge pclk_tx);
		#1;
	endtask

	task automatic pulse_fct_now(input int n);
		repeat (n)
		begin
			send_fct_now = 1'b1;
			tick();
			send_fct_now = 1'b0;
			tick();
		end
	endtask

	task automatic pulse_gotfct();
		gotfct_tx = 1'b1;
		tick();
		gotfct_tx = 1'b0;
		tick();
	endtask

	task automatic pop_char(output spw_char_req_t c);
		int waited;
		waited = 0;
		while (dec_q.size() == 0)
		begin
			tick();
			waited++;
			if (waited > 500)
				report_error("no character decoded from the line");
		end
		c = dec_q.pop_front();
	endtask

	// Next character that is not a NULL
	task automatic pop_visible(output spw_char_req_t c);
		int nulls;
		nulls = 0;
		pop_char(c);
		while (c.kind == CHAR_NULL)
		begin
			nulls++;
			if (nulls > 40)
				report_error("only NULLs where a character was expected");
			pop_char(c);
		end
	endtask

	task automatic check_char(input spw_char_req_t c, input spw_char_kind_t kind,
		input logic [7:0] payload);
		assert (c.kind == kind)
			else report_mismatch("char kind", kind, c.kind);
		if (kind == CHAR_DATA || kind == CHAR_TIME)
			assert (c.payload == payload)
				else report_mismatch("char payload", payload, c.payload);
	endtask

	task automatic send_words(input spw_nchar_t words[$]);
		int waited;
		foreach (words[i])
		begin
			tx_data_in   = words[i];
			process_data = 1'b1;
			waited       = 0;
			do
			begin
				tick();
				waited++;
				if (waited > 400)
					report_error("data word never taken");
			end
			while (!ready_tx_data);
		end
		process_data = 1'b0;
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic test_reset_nulls();
		spw_char_req_t c;
		@(negedge pclk_tx);
		assert (tx_dout_e == 1'b0) else report_mismatch("tx_dout_e", 0, tx_dout_e);
		assert (tx_sout_e == 1'b0) else report_mismatch("tx_sout_e", 0, tx_sout_e);
		assert (ready_tx_data == 1'b0) else report_mismatch("ready_tx_data", 0, ready_tx_data);
		assert (ready_tx_timecode == 1'b0)
			else report_mismatch("ready_tx_timecode", 0, ready_tx_timecode);
		assert (fct_great_than_zero == 1'b0)
			else report_mismatch("fct_great_than_zero", 0, fct_great_than_zero);
		tick();
		send_null_tx = 1'b1;
		repeat (10)
		begin
			pop_char(c);
			check_char(c, CHAR_NULL, 8'h00);
		end
	endtask

	task automatic count_fcts(input int window, input int expected);
		spw_char_req_t c;
		int            fcts;
		fcts = 0;
		repeat (window)
		begin
			pop_char(c);
			if (c.kind == CHAR_FCT)
				fcts++;
			else
				check_char(c, CHAR_NULL, 8'h00);
		end
		assert (fcts == expected) else report_mismatch("FCT count", expected, fcts);
	endtask

	task automatic test_fct_requests();
		spw_char_req_t c;
		pulse_fct_now(3);
		dec_q.delete();
		// FCTs pending but not yet permitted
		repeat (4)
		begin
			pop_char(c);
			check_char(c, CHAR_NULL, 8'h00);
		end
		send_fct_tx = 1'b1;
		count_fcts(15, 3);
		send_fct_tx = 1'b0;
		pulse_fct_now(10);
		dec_q.delete();
		send_fct_tx = 1'b1;
		count_fcts(20, 7);
	endtask

	task automatic test_credit();
		spw_char_req_t c;
		int            datas;
		tx_data_in   = '{flag: 1'b0, data: 8'h5a};
		process_data = 1'b1;
		dec_q.delete();
		repeat (6)
		begin
			pop_char(c);
			check_char(c, CHAR_NULL, 8'h00);
			assert (fct_great_than_zero == 1'b0)
				else report_mismatch("fct_great_than_zero", 0, fct_great_than_zero);
		end
		pulse_gotfct();
		assert (fct_great_than_zero == 1'b1)
			else report_mismatch("fct_great_than_zero", 1, fct_great_than_zero);
		datas = 0;
		while (datas < 8)
		begin
			pop_visible(c);
			check_char(c, CHAR_DATA, 8'h5a);
			datas++;
		end
		repeat (4)
		begin
			pop_char(c);
			check_char(c, CHAR_NULL, 8'h00);
		end
		process_data = 1'b0;
		assert (fct_great_than_zero == 1'b0)
			else report_mismatch("fct_great_than_zero", 0, fct_great_than_zero);
	endtask

	task automatic test_packet();
		spw_nchar_t    words[$];
		spw_char_req_t c;
		int            start;
		for (int i = 0; i < 6; i++)
			words.push_back('{flag: 1'b0, data: 8'($random(seed))});
		words.push_back('{flag: 1'b1, data: 8'h00});
		words.push_back('{flag: 1'b1, data: 8'h01});
		pulse_gotfct();
		dec_q.delete();
		start = data_pulses;
		send_words(words);
		foreach (words[i])
		begin
			pop_visible(c);
			if (!words[i].flag)
				check_char(c, CHAR_DATA, words[i].data);
			else if (words[i].data[0])
				check_char(c, CHAR_EEP, 8'h00);
			else
				check_char(c, CHAR_EOP, 8'h00);
		end
		assert (data_pulses - start == 8)
			else report_mismatch("ready_tx_data pulses", 8, data_pulses - start);
	endtask

	task automatic test_timecode();
		spw_char_req_t c;
		logic [7:0]    tval;
		logic [7:0]    dval;
		logic          got_d;
		logic          got_t;
		int            t_start;
		int            waited;
		tval = 8'($random(seed));
		dval = 8'($random(seed));
		send_fct_tx = 1'b0;
		pulse_fct_now(2);
		pulse_gotfct();
		dec_q.delete();
		t_start = tcode_pulses;
		tx_data_in      = '{flag: 1'b0, data: dval};
		tx_tcode_in     = tval;
		process_data    = 1'b1;
		send_fct_tx     = 1'b1;
		tcode_rdy_trnsp = 1'b1;
		got_d  = 1'b0;
		got_t  = 1'b0;
		waited = 0;
		while (!(got_d && got_t))
		begin
			tick();
			waited++;
			if (waited > 400)
				report_error("time code or data word never completed");
			if (ready_tx_data)
			begin
				process_data = 1'b0;
				got_d        = 1'b1;
			end
			if (ready_tx_timecode)
			begin
				tcode_rdy_trnsp = 1'b0;
				got_t           = 1'b1;
			end
		end
		pop_visible(c);
		check_char(c, CHAR_TIME, tval);
		pop_visible(c);
		check_char(c, CHAR_FCT, 8'h00);
		pop_visible(c);
		check_char(c, CHAR_FCT, 8'h00);
		pop_visible(c);
		check_char(c, CHAR_DATA, dval);
		assert (tcode_pulses - t_start == 1)
			else report_mismatch("ready_tx_timecode pulses", 1, tcode_pulses - t_start);
	endtask

	task automatic freeze_line(input int after);
		logic d;
		logic s;
		repeat (after) tick();
		send_null_tx = 1'b0;
		tick();
		d = tx_dout_e;
		s = tx_sout_e;
		repeat (5)
		begin
			tick();
			assert (tx_dout_e == d) else report_mismatch("tx_dout_e", d, tx_dout_e);
			assert (tx_sout_e == s) else report_mismatch("tx_sout_e", s, tx_sout_e);
		end
		send_null_tx = 1'b1;
	endtask

	task automatic test_freeze();
		spw_nchar_t    words[$];
		spw_char_req_t c;
		for (int i = 0; i < 3; i++)
			words.push_back('{flag: 1'b0, data: 8'($random(seed))});
		dec_q.delete();
		fork
			send_words(words);
			begin
				freeze_line(13);
				freeze_line(7);
			end
		join
		foreach (words[i])
		begin
			pop_visible(c);
			check_char(c, CHAR_DATA, words[i].data);
		end
	endtask

	// --------------------
	// Main sequence and watchdog
	// --------------------
	initial
	begin
		seed            = 1844;
		error_count     = 0;
		data_pulses     = 0;
		tcode_pulses    = 0;
		send_null_tx    = 1'b0;
		send_fct_tx     = 1'b0;
		tx_data_in      = '0;
		process_data    = 1'b0;
		gotfct_tx       = 1'b0;
		send_fct_now    = 1'b0;
		tx_tcode_in     = '0;
		tcode_rdy_trnsp = 1'b0;
		@(posedge enable_tx);
		test_reset_nulls();
		test_fct_requests();
		test_credit();
		test_packet();
		test_timecode();
		test_freeze();
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		#((BUDGET + RST_CYCLES) * CLK_PERIOD * 2);
		$display("Timeout: tests did not finish in time");
		$display("Verification failed");
		$fatal(1);
	end

endmodule

//--- vlog.f
+incdir+hw
hw/spw_char_pkg.sv
hw/spw_tx_pkg.sv
hw/spw_tx_flow_ctl.sv
hw/spw_tx_seq.sv
hw/spw_tx_char_enc.sv
hw/spw_tx_top.sv
verif/spw_tx_clkgen.sv
verif/spw_tx_assert.sv
verif/spw_tx_tb.sv

//--- Bender.yml
package:
  name: spw_tx

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/spw_char_pkg.sv
      - hw/spw_tx_pkg.sv
      - hw/spw_tx_flow_ctl.sv
      - hw/spw_tx_seq.sv
      - hw/spw_tx_char_enc.sv
      - hw/spw_tx_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/spw_tx_clkgen.sv
      - verif/spw_tx_assert.sv
      - verif/spw_tx_tb.sv
